// File: source/dacPkg.sv
package dacPkg;

    localparam int CUR_W = 20; // nA, room for iref plus margin
    localparam int SUM_W = 24; // every cell on one output still fits
    localparam int MV_W  = 12; // signed mV
    localparam int CAL_W = 5;

    typedef logic [CUR_W-1:0]        current_t;
    typedef logic [SUM_W-1:0]        sum_t;
    typedef logic signed [MV_W-1:0]  supplyMv_t;
    typedef logic [CAL_W-1:0]        calSel_t;

    // analog test bus routing
    typedef enum logic [1:0] {
        ATB_OFF    = 2'b00, // both lines floating
        ATB_SUPPLY = 2'b01, // vdd18 on atb1, vss on atb0
        ATB_BIAS   = 2'b10, // vdd08 on atb1, vcas on atb0
        ATB_CAL    = 2'b11  // calibration current on atb1
    } atbMode_t;

    localparam current_t IREF_NA       = current_t'(500000);
    localparam current_t UNARY_NA      = current_t'(IREF_NA * 2 / 5); // iref / 2.5
    localparam current_t BINARY_MSB_NA = current_t'(UNARY_NA / 2);

    localparam int CUR_TOL_DIV = 10; // +/- 10 % of nominal

    localparam supplyMv_t VDD18_MIN = 12'sd1710;
    localparam supplyMv_t VDD18_MAX = 12'sd1890;
    localparam supplyMv_t VDD08_MIN = 12'sd760; // also used for vcas
    localparam supplyMv_t VDD08_MAX = 12'sd840;
    localparam supplyMv_t VSS_MIN   = -12'sd50;
    localparam supplyMv_t VSS_MAX   = 12'sd50;

    // nominal current of binary cell k, halving from the MSB down
    function automatic current_t binNominal(int k, int numBin);
        return current_t'(BINARY_MSB_NA >> (numBin - 1 - k));
    endfunction

    // inclusive window of nominal +/- nominal/CUR_TOL_DIV
    function automatic logic curInWindow(current_t val, current_t nom);
        current_t delta;
        delta = current_t'(nom / CUR_TOL_DIV);
        return (val >= nom - delta) && (val <= nom + delta);
    endfunction

    function automatic logic mvInWindow(supplyMv_t val, supplyMv_t lo, supplyMv_t hi);
        return (val >= lo) && (val <= hi);
    endfunction

    // voltages share the test bus with currents
    function automatic sum_t sextMv(supplyMv_t val);
        return {{(SUM_W - MV_W){val[MV_W-1]}}, val};
    endfunction

endpackage

// File: source/biasMonitor.sv
module biasMonitor #(
    parameter int NUM_THERM = 17,
    parameter int NUM_BIN   = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  dacPkg::current_t  iref,
    input  dacPkg::supplyMv_t vdd18,
    input  dacPkg::supplyMv_t vdd08,
    input  dacPkg::supplyMv_t vcas,
    input  dacPkg::supplyMv_t vss,
    input  dacPkg::current_t  thermCur [NUM_THERM],
    input  dacPkg::current_t  binCur [NUM_BIN],
    input  dacPkg::current_t  redCur,
    output logic              supplyOk,
    output logic              cellsOk,
    output dacPkg::supplyMv_t vdd18Q,
    output dacPkg::supplyMv_t vdd08Q,
    output dacPkg::supplyMv_t vcasQ,
    output dacPkg::supplyMv_t vssQ
);
    import dacPkg::*;

    logic                 irefOk;
    logic                 vdd18Ok;
    logic                 vdd08Ok;
    logic                 vcasOk;
    logic                 vssOk;
    logic [NUM_THERM-1:0] thermOk; // one flag per unary cell
    logic [NUM_BIN-1:0]   binOk;
    logic                 redOk;

    supplyMv_t vdd18D; // first copy, lines up with the window flags
    supplyMv_t vdd08D;
    supplyMv_t vcasD;
    supplyMv_t vssD;

    // compare stage, one window result per input
    always_ff @(posedge clk) begin
        if (rst) begin
            irefOk  <= 1'b0;
            vdd18Ok <= 1'b0;
            vdd08Ok <= 1'b0;
            vcasOk  <= 1'b0;
            vssOk   <= 1'b0;
            thermOk <= '0;
            binOk   <= '0;
            redOk   <= 1'b0;
        end else begin
            irefOk  <= curInWindow(iref, IREF_NA);
            vdd18Ok <= mvInWindow(vdd18, VDD18_MIN, VDD18_MAX);
            vdd08Ok <= mvInWindow(vdd08, VDD08_MIN, VDD08_MAX);
            vcasOk  <= mvInWindow(vcas, VDD08_MIN, VDD08_MAX); // cascode sits at 0.8 V
            vssOk   <= mvInWindow(vss, VSS_MIN, VSS_MAX);
            for (int t = 0; t < NUM_THERM; t++) begin
                thermOk[t] <= curInWindow(thermCur[t], UNARY_NA);
            end
            for (int k = 0; k < NUM_BIN; k++) begin
                binOk[k] <= curInWindow(binCur[k], binNominal(k, NUM_BIN));
            end
            redOk <= curInWindow(redCur, binNominal(0, NUM_BIN)); // same weight as LSB
        end
    end

    // reduce stage
    always_ff @(posedge clk) begin
        if (rst) begin
            supplyOk <= 1'b0;
            cellsOk  <= 1'b0;
        end else begin
            supplyOk <= irefOk & vdd18Ok & vdd08Ok & vcasOk & vssOk;
            cellsOk  <= (&thermOk) & (&binOk) & redOk;
        end
    end

    // supply values for the test bus, two deep to match the summer
    always_ff @(posedge clk) begin
        vdd18D <= vdd18;
        vdd08D <= vdd08;
        vcasD  <= vcas;
        vssD   <= vss;
        vdd18Q <= vdd18D;
        vdd08Q <= vdd08D;
        vcasQ  <= vcasD;
        vssQ   <= vssD;
    end

endmodule

// File: source/steerDecode.sv
module steerDecode #(
    parameter int  NUM_THERM = 17,
    parameter int  NUM_BIN   = 6,
    localparam int NUM_CELLS = NUM_BIN + NUM_THERM + 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_BIN:0]       dataIn, // top pair is a spare with no cell behind it
    input  logic [NUM_BIN:0]       dataInB,
    input  logic [NUM_THERM-1:0]   dataTherm,
    input  logic [NUM_THERM-1:0]   dataThermB,
    input  dacPkg::calSel_t        dataIcal,
    input  dacPkg::atbMode_t       atbEna,
    input  logic                   pdb,
    input  dacPkg::current_t       thermCur [NUM_THERM],
    input  dacPkg::current_t       binCur [NUM_BIN],
    input  dacPkg::current_t       redCur,
    output logic [NUM_CELLS-1:0]   toOut,
    output logic [NUM_CELLS-1:0]   toOutB,
    output dacPkg::current_t       cellCur [NUM_CELLS],
    output dacPkg::calSel_t        calSel,
    output dacPkg::atbMode_t       atbMode,
    output logic                   pdbQ
);
    import dacPkg::*;

    logic [NUM_CELLS-1:0] cellData; // data pair mapped onto the cell array
    logic [NUM_CELLS-1:0] cellDataB;
    logic [NUM_CELLS-1:0] calExcl;  // cells routed to ical instead
    current_t             cellCurNext [NUM_CELLS];

    // cell order: LSB, redundant LSB, binary 1 and up, then unary
    always_comb begin
        cellData[0]    = dataIn[0];
        cellDataB[0]   = dataInB[0];
        cellCurNext[0] = binCur[0];
        cellData[1]    = dataIn[0]; // redundant cell follows the LSB
        cellDataB[1]   = dataInB[0];
        cellCurNext[1] = redCur;
        for (int b = 1; b < NUM_BIN; b++) begin
            cellData[b+1]    = dataIn[b];
            cellDataB[b+1]   = dataInB[b];
            cellCurNext[b+1] = binCur[b];
        end
        for (int t = 0; t < NUM_THERM; t++) begin
            cellData[NUM_BIN+1+t]    = dataTherm[t];
            cellDataB[NUM_BIN+1+t]   = dataThermB[t];
            cellCurNext[NUM_BIN+1+t] = thermCur[t];
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_CELLS; c++) begin
            calExcl[c] = (dataIcal != '0) && (int'(dataIcal) == c);
        end
        // calibrating the redundant cell also pulls the LSB out
        calExcl[0] = (dataIcal == calSel_t'(1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            toOut   <= '0;
            toOutB  <= '0;
            calSel  <= '0;
            atbMode <= ATB_OFF;
            pdbQ    <= 1'b0;
        end else begin
            toOut   <= cellData & ~cellDataB & ~calExcl; // 1/1 or 0/0 steers nowhere
            toOutB  <= ~cellData & cellDataB & ~calExcl;
            calSel  <= dataIcal;
            atbMode <= atbEna;
            pdbQ    <= pdb;
        end
    end

    always_ff @(posedge clk) begin
        cellCur <= cellCurNext;
    end

endmodule

// File: source/currentSummer.sv
module currentSummer #(
    parameter int  NUM_THERM = 17,
    parameter int  NUM_BIN   = 6,
    localparam int NUM_CELLS = NUM_BIN + NUM_THERM + 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_CELLS-1:0] toOut,
    input  logic [NUM_CELLS-1:0] toOutB,
    input  dacPkg::current_t     cellCur [NUM_CELLS],
    input  dacPkg::calSel_t      calSel,
    input  dacPkg::atbMode_t     atbMode,
    input  logic                 pdbQ,
    output dacPkg::sum_t         sumOut,
    output dacPkg::sum_t         sumOutB,
    output dacPkg::current_t     calCur,
    output logic                 calValid,
    output dacPkg::atbMode_t     modeQ,
    output logic                 pdbQQ
);
    import dacPkg::*;

    sum_t     sumNext;
    sum_t     sumNextB;
    current_t calCurNext;
    logic     calValidNext;

    always_comb begin
        sumNext  = '0;
        sumNextB = '0;
        for (int c = 0; c < NUM_CELLS; c++) begin
            if (toOut[c]) sumNext = sumNext + sum_t'(cellCur[c]);
            if (toOutB[c]) sumNextB = sumNextB + sum_t'(cellCur[c]);
        end
    end

    // code 0 and codes past the last cell leave ical floating
    always_comb begin
        calValidNext = (calSel != '0) && (int'(calSel) < NUM_CELLS);
        calCurNext   = '0;
        for (int c = 1; c < NUM_CELLS; c++) begin
            if (int'(calSel) == c) calCurNext = cellCur[c];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            calValid <= 1'b0;
            modeQ    <= ATB_OFF;
            pdbQQ    <= 1'b0;
        end else begin
            calValid <= calValidNext;
            modeQ    <= atbMode;
            pdbQQ    <= pdbQ;
        end
    end

    always_ff @(posedge clk) begin
        sumOut  <= sumNext;
        sumOutB <= sumNextB;
        calCur  <= calCurNext;
    end

endmodule

// File: source/outputStage.sv
module outputStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              supplyOk,
    input  logic              cellsOk,
    input  dacPkg::sum_t      sumOut,
    input  dacPkg::sum_t      sumOutB,
    input  dacPkg::current_t  calCur,
    input  logic              calValid,
    input  dacPkg::atbMode_t  modeQ,
    input  logic              pdbQQ,
    input  dacPkg::supplyMv_t vdd18Q,
    input  dacPkg::supplyMv_t vdd08Q,
    input  dacPkg::supplyMv_t vcasQ,
    input  dacPkg::supplyMv_t vssQ,
    output dacPkg::sum_t      iout,
    output dacPkg::sum_t      ioutb,
    output logic              ioutDrive, // one flag covers the differential pair
    output dacPkg::current_t  ical,
    output logic              icalDrive,
    output dacPkg::sum_t      atb1,
    output logic              atb1Drive,
    output dacPkg::sum_t      atb0,
    output logic              atb0Drive
);
    import dacPkg::*;

    logic inputsOk;

    assign inputsOk = supplyOk & cellsOk;

    always_ff @(posedge clk) begin
        if (rst) begin
            iout      <= '0;
            ioutb     <= '0;
            ioutDrive <= 1'b0;
            ical      <= '0;
            icalDrive <= 1'b0;
            atb1      <= '0;
            atb1Drive <= 1'b0;
            atb0      <= '0;
            atb0Drive <= 1'b0;
        end else if (inputsOk) begin // out-of-range inputs freeze everything
            if (!pdbQQ) begin
                ioutDrive <= 1'b0; // powered down, values kept but floating
                icalDrive <= 1'b0;
                atb1Drive <= 1'b0;
                atb0Drive <= 1'b0;
            end else begin
                iout      <= sumOut;
                ioutb     <= sumOutB;
                ioutDrive <= 1'b1;
                ical      <= calCur;
                icalDrive <= calValid;
                case (modeQ)
                    ATB_SUPPLY: begin
                        atb1      <= sextMv(vdd18Q);
                        atb1Drive <= 1'b1;
                        atb0      <= sextMv(vssQ);
                        atb0Drive <= 1'b1;
                    end
                    ATB_BIAS: begin
                        atb1      <= sextMv(vdd08Q);
                        atb1Drive <= 1'b1;
                        atb0      <= sextMv(vcasQ);
                        atb0Drive <= 1'b1;
                    end
                    ATB_CAL: begin
                        atb1      <= sum_t'(calCur);
                        atb1Drive <= calValid; // nothing selected leaves atb1 floating
                        atb0      <= '0;
                        atb0Drive <= 1'b0;
                    end
                    default: begin
                        atb1      <= '0;
                        atb1Drive <= 1'b0;
                        atb0      <= '0;
                        atb0Drive <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// File: source/currentSteeringDac.sv
module currentSteeringDac #(
    parameter int  NUM_THERM = 17,
    parameter int  NUM_BIN   = 6,
    localparam int NUM_CELLS = NUM_BIN + NUM_THERM + 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pdb,
    input  dacPkg::atbMode_t     atbEna,
    input  dacPkg::current_t     iref,
    input  dacPkg::supplyMv_t    vdd18,
    input  dacPkg::supplyMv_t    vdd08,
    input  dacPkg::supplyMv_t    vcas,
    input  dacPkg::supplyMv_t    vss,
    input  dacPkg::current_t     thermCur [NUM_THERM],
    input  dacPkg::current_t     binCur [NUM_BIN],
    input  dacPkg::current_t     redCur,
    input  logic [NUM_BIN:0]     dataIn,
    input  logic [NUM_BIN:0]     dataInB,
    input  logic [NUM_THERM-1:0] dataTherm,
    input  logic [NUM_THERM-1:0] dataThermB,
    input  dacPkg::calSel_t      dataIcal,
    output dacPkg::sum_t         iout,
    output dacPkg::sum_t         ioutb,
    output logic                 ioutDrive,
    output dacPkg::current_t     ical,
    output logic                 icalDrive,
    output dacPkg::sum_t         atb1,
    output logic                 atb1Drive,
    output dacPkg::sum_t         atb0,
    output logic                 atb0Drive
);
    import dacPkg::*;

    logic                 supplyOk;
    logic                 cellsOk;
    supplyMv_t            vdd18Q;
    supplyMv_t            vdd08Q;
    supplyMv_t            vcasQ;
    supplyMv_t            vssQ;
    logic [NUM_CELLS-1:0] toOut;  // decode to execute
    logic [NUM_CELLS-1:0] toOutB;
    current_t             cellCur [NUM_CELLS];
    calSel_t              calSel;
    atbMode_t             atbMode;
    logic                 pdbQ;
    sum_t                 sumOut; // execute to result
    sum_t                 sumOutB;
    current_t             calCur;
    logic                 calValid;
    atbMode_t             modeQ;
    logic                 pdbQQ;

    // range checks run beside decode and execute
    biasMonitor #(
        .NUM_THERM (NUM_THERM),
        .NUM_BIN   (NUM_BIN)
    ) biasMonitor_inst (
        .clk      (clk),
        .rst      (rst),
        .iref     (iref),
        .vdd18    (vdd18),
        .vdd08    (vdd08),
        .vcas     (vcas),
        .vss      (vss),
        .thermCur (thermCur),
        .binCur   (binCur),
        .redCur   (redCur),
        .supplyOk (supplyOk),
        .cellsOk  (cellsOk),
        .vdd18Q   (vdd18Q),
        .vdd08Q   (vdd08Q),
        .vcasQ    (vcasQ),
        .vssQ     (vssQ)
    );

    steerDecode #(
        .NUM_THERM (NUM_THERM),
        .NUM_BIN   (NUM_BIN)
    ) steerDecode_inst (
        .clk        (clk),
        .rst        (rst),
        .dataIn     (dataIn),
        .dataInB    (dataInB),
        .dataTherm  (dataTherm),
        .dataThermB (dataThermB),
        .dataIcal   (dataIcal),
        .atbEna     (atbEna),
        .pdb        (pdb),
        .thermCur   (thermCur),
        .binCur     (binCur),
        .redCur     (redCur),
        .toOut      (toOut),
        .toOutB     (toOutB),
        .cellCur    (cellCur),
        .calSel     (calSel),
        .atbMode    (atbMode),
        .pdbQ       (pdbQ)
    );

    currentSummer #(
        .NUM_THERM (NUM_THERM),
        .NUM_BIN   (NUM_BIN)
    ) currentSummer_inst (
        .clk      (clk),
        .rst      (rst),
        .toOut    (toOut),
        .toOutB   (toOutB),
        .cellCur  (cellCur),
        .calSel   (calSel),
        .atbMode  (atbMode),
        .pdbQ     (pdbQ),
        .sumOut   (sumOut),
        .sumOutB  (sumOutB),
        .calCur   (calCur),
        .calValid (calValid),
        .modeQ    (modeQ),
        .pdbQQ    (pdbQQ)
    );

    outputStage outputStage_inst (
        .clk       (clk),
        .rst       (rst),
        .supplyOk  (supplyOk),
        .cellsOk   (cellsOk),
        .sumOut    (sumOut),
        .sumOutB   (sumOutB),
        .calCur    (calCur),
        .calValid  (calValid),
        .modeQ     (modeQ),
        .pdbQQ     (pdbQQ),
        .vdd18Q    (vdd18Q),
        .vdd08Q    (vdd08Q),
        .vcasQ     (vcasQ),
        .vssQ      (vssQ),
        .iout      (iout),
        .ioutb     (ioutb),
        .ioutDrive (ioutDrive),
        .ical      (ical),
        .icalDrive (icalDrive),
        .atb1      (atb1),
        .atb1Drive (atb1Drive),
        .atb0      (atb0),
        .atb0Drive (atb0Drive)
    );

endmodule

// File: dv/clockGen.sv
module clockGen #(
    parameter int HALF_PERIOD = 4,  // ns, 8 ns clock
    parameter int RST_CYCLES  = 5
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;  // drops right after the last reset edge
    end

endmodule

// File: dv/tbCurrentSteeringDac.sv
module tbCurrentSteeringDac;
    timeunit 1ns;
    timeprecision 100ps;

    import dacPkg::*;

    localparam int NUM_THERM   = 17;
    localparam int NUM_BIN     = 6;
    localparam int NUM_CELLS   = NUM_BIN + NUM_THERM + 1;
    localparam int NOM_IREF    = 500000;          // nA
    localparam int NOM_UNARY   = NOM_IREF * 2 / 5; // iref / 2.5
    localparam int NOM_BIN_MSB = NOM_UNARY / 2;

    logic                 clk;
    logic                 rst;
    logic                 pdb;
    atbMode_t             atbEna;
    current_t             iref;
    supplyMv_t            vdd18;
    supplyMv_t            vdd08;
    supplyMv_t            vcas;
    supplyMv_t            vss;
    current_t             thermCur [NUM_THERM];
    current_t             binCur [NUM_BIN];
    current_t             redCur;
    logic [NUM_BIN:0]     dataIn;
    logic [NUM_BIN:0]     dataInB;
    logic [NUM_THERM-1:0] dataTherm;
    logic [NUM_THERM-1:0] dataThermB;
    calSel_t              dataIcal;
    sum_t                 iout;
    sum_t                 ioutb;
    logic                 ioutDrive;
    current_t             ical;
    logic                 icalDrive;
    sum_t                 atb1;
    logic                 atb1Drive;
    sum_t                 atb0;
    logic                 atb0Drive;

    int          errorCount;
    int          checkCount;
    logic [31:0] seed;

    clockGen clockGen_inst (
        .clk (clk),
        .rst (rst)
    );

    currentSteeringDac #(
        .NUM_THERM (NUM_THERM),
        .NUM_BIN   (NUM_BIN)
    ) currentSteeringDac_inst (
        .clk        (clk),
        .rst        (rst),
        .pdb        (pdb),
        .atbEna     (atbEna),
        .iref       (iref),
        .vdd18      (vdd18),
        .vdd08      (vdd08),
        .vcas       (vcas),
        .vss        (vss),
        .thermCur   (thermCur),
        .binCur     (binCur),
        .redCur     (redCur),
        .dataIn     (dataIn),
        .dataInB    (dataInB),
        .dataTherm  (dataTherm),
        .dataThermB (dataThermB),
        .dataIcal   (dataIcal),
        .iout       (iout),
        .ioutb      (ioutb),
        .ioutDrive  (ioutDrive),
        .ical       (ical),
        .icalDrive  (icalDrive),
        .atb1       (atb1),
        .atb1Drive  (atb1Drive),
        .atb0       (atb0),
        .atb0Drive  (atb0Drive)
    );

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // nominal current of cell c in the unified order
    function automatic int cellNominal(input int c);
        if (c <= 1) begin
            return NOM_BIN_MSB >> (NUM_BIN - 1); // binary 0 and its redundant twin
        end
        if (c <= NUM_BIN) begin
            return NOM_BIN_MSB >> (NUM_BIN - c);
        end
        return NOM_UNARY;
    endfunction

    function automatic int totalCurrent();
        int acc;
        acc = 0;
        for (int c = 0; c < NUM_CELLS; c++) begin
            acc += cellNominal(c);
        end
        return acc;
    endfunction

    // current pulled out of both outputs by calibration code
    function automatic int calExcluded(input int code);
        if (code == 1) begin
            return 2 * cellNominal(0);
        end
        if (code >= 2 && code < NUM_CELLS) begin
            return cellNominal(code);
        end
        return 0;
    endfunction

    // expected output sum for the data pairs now driven
    function automatic logic [31:0] modelSum(input logic sideB);
        logic [31:0] acc;
        logic        d;
        logic        db;
        logic        excluded;
        acc = 0;
        for (int c = 0; c < NUM_CELLS; c++) begin
            if (c <= 1) begin
                d  = dataIn[0];
                db = dataInB[0];
            end else if (c <= NUM_BIN) begin
                d  = dataIn[c-1];
                db = dataInB[c-1];
            end else begin
                d  = dataTherm[c-NUM_BIN-1];
                db = dataThermB[c-NUM_BIN-1];
            end
            excluded = (dataIcal != 0 && int'(dataIcal) == c) || (dataIcal == 1 && c == 0);
            if (!excluded && (sideB ? (!d && db) : (d && !db))) begin
                acc += cellNominal(c);
            end
        end
        return acc;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic abortOnTimeout(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic setNominal();
        pdb    = 1'b1;
        atbEna = ATB_OFF;
        iref   = current_t'(NOM_IREF);
        vdd18  = 12'sd1800;
        vdd08  = 12'sd800;
        vcas   = 12'sd800;
        vss    = 12'sd0;
        for (int t = 0; t < NUM_THERM; t++) begin
            thermCur[t] = current_t'(NOM_UNARY);
        end
        for (int k = 0; k < NUM_BIN; k++) begin
            binCur[k] = current_t'(cellNominal(k == 0 ? 0 : k + 1));
        end
        redCur     = current_t'(cellNominal(1));
        dataIn     = '0;  // every cell to ioutb
        dataInB    = '1;
        dataTherm  = '0;
        dataThermB = '1;
        dataIcal   = '0;
    endtask

    task automatic randomData();
        seed       = lcgStep(seed);
        dataIn     = seed[16 +: NUM_BIN+1]; // upper bits since the low ones cycle fast
        dataInB    = ~seed[16 +: NUM_BIN+1];
        seed       = lcgStep(seed);
        dataTherm  = seed[14 +: NUM_THERM];
        dataThermB = ~seed[14 +: NUM_THERM];
    endtask

    // sampling edge plus three pipeline edges
    task automatic waitPipeline();
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic waitResetRelease(input int limit);
        int n;
        n = 0;
        while (rst !== 1'b0 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rst !== 1'b0) begin
            abortOnTimeout("reset release");
        end
    endtask

    task automatic waitIoutDriven(input int limit);
        int n;
        n = 0;
        while (ioutDrive !== 1'b1 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ioutDrive !== 1'b1) begin
            abortOnTimeout("iout drive after power-up");
        end
    endtask

    task automatic checkDrives(input string what, input logic [3:0] exp);
        checkValue({what, " ioutDrive"}, ioutDrive, exp[3]);
        checkValue({what, " icalDrive"}, icalDrive, exp[2]);
        checkValue({what, " atb1Drive"}, atb1Drive, exp[1]);
        checkValue({what, " atb0Drive"}, atb0Drive, exp[0]);
    endtask

    task automatic testReset();
        checkDrives("after reset", 4'b0000);
        setNominal();
        pdb = 1'b0;
        waitPipeline();
        checkDrives("powered down", 4'b0000);
        pdb = 1'b1;
        waitIoutDriven(10);
        checkValue("first iout", iout, modelSum(1'b0));
        checkValue("first ioutb", ioutb, modelSum(1'b1));
    endtask

    task automatic testSteering();
        for (int i = 0; i < 40; i++) begin
            setNominal();
            randomData();
            waitPipeline();
            checkValue("steer iout", iout, modelSum(1'b0));
            checkValue("steer ioutb", ioutb, modelSum(1'b1));
            checkValue("steer total", iout + ioutb, totalCurrent());
        end
        dataTherm[3]  = 1'b1; // 1/1 pair steers the cell nowhere
        dataThermB[3] = 1'b1;
        waitPipeline();
        checkValue("1/1 pair iout", iout, modelSum(1'b0));
        checkValue("1/1 pair total", iout + ioutb, totalCurrent() - NOM_UNARY);
        dataIn[0]  = 1'b0;    // 0/0 on the LSB drops it and the redundant cell
        dataInB[0] = 1'b0;
        waitPipeline();
        checkValue("0/0 pair ioutb", ioutb, modelSum(1'b1));
        checkValue("0/0 pair total", iout + ioutb,
                   totalCurrent() - NOM_UNARY - 2 * cellNominal(0));
    endtask

    task automatic testCalibration();
        logic valid;
        for (int code = 0; code < 32; code++) begin
            setNominal();
            randomData();
            dataIcal = calSel_t'(code);
            valid    = (code >= 1 && code < NUM_CELLS);
            waitPipeline();
            checkValue("cal iout", iout, modelSum(1'b0));
            checkValue("cal ioutb", ioutb, modelSum(1'b1));
            checkValue("cal total", iout + ioutb, totalCurrent() - calExcluded(code));
            checkValue("icalDrive", icalDrive, valid);
            if (valid) begin
                checkValue("ical", ical, cellNominal(code));
            end
        end
    endtask

    task automatic testTestBus();
        atbMode_t mode;
        for (int m = 0; m < 4; m++) begin
            setNominal();
            vdd18    = 12'sd1750; // distinct values so swapped lines show up
            vdd08    = 12'sd780;
            vcas     = 12'sd820;
            vss      = -12'sd30;
            dataIcal = 5'd9;
            mode     = atbMode_t'(m);
            atbEna   = mode;
            waitPipeline();
            case (mode)
                ATB_SUPPLY: begin
                    checkValue("supply atb1", atb1, sum_t'(1750));
                    checkValue("supply atb0", atb0, sum_t'(-30));
                    checkValue("supply atb1Drive", atb1Drive, 1);
                    checkValue("supply atb0Drive", atb0Drive, 1);
                end
                ATB_BIAS: begin
                    checkValue("bias atb1", atb1, sum_t'(780));
                    checkValue("bias atb0", atb0, sum_t'(820));
                    checkValue("bias atb1Drive", atb1Drive, 1);
                    checkValue("bias atb0Drive", atb0Drive, 1);
                end
                ATB_CAL: begin
                    checkValue("cal atb1", atb1, cellNominal(9));
                    checkValue("cal atb1Drive", atb1Drive, 1);
                    checkValue("cal atb0Drive", atb0Drive, 0);
                end
                default: begin
                    checkValue("off atb1Drive", atb1Drive, 0);
                    checkValue("off atb0Drive", atb0Drive, 0);
                end
            endcase
        end
        dataIcal = '0; // with no cell selected atb1 floats
        waitPipeline();
        checkValue("empty cal atb1Drive", atb1Drive, 0);
    endtask

    task automatic testPowerDown();
        setNominal();
        atbEna   = ATB_SUPPLY;
        dataIcal = 5'd20;
        waitPipeline();
        checkDrives("before power-up", 4'b1111);
        pdb = 1'b0;
        waitPipeline();
        checkDrives("power-down", 4'b0000);
        pdb        = 1'b1;
        dataIn     = '1; // every cell to iout so the update shows
        dataInB    = '0;
        dataTherm  = '1;
        dataThermB = '0;
        waitPipeline();
        checkDrives("after power-up", 4'b1111);
        checkValue("after power-up iout", iout, modelSum(1'b0));
        checkValue("after power-up ioutb", ioutb, modelSum(1'b1));
    endtask

    task automatic testHoldOnFault();
        sum_t       ioutSeen;
        sum_t       ioutbSeen;
        current_t   icalSeen;
        sum_t       atb1Seen;
        sum_t       atb0Seen;
        logic [3:0] drivesSeen;
        for (int f = 0; f < 2; f++) begin
            setNominal();
            atbEna   = ATB_SUPPLY;
            dataIcal = 5'd12;
            waitPipeline();
            ioutSeen   = iout;
            ioutbSeen  = ioutb;
            icalSeen   = ical;
            atb1Seen   = atb1;
            atb0Seen   = atb0;
            drivesSeen = {ioutDrive, icalDrive, atb1Drive, atb0Drive};
            if (f == 0) begin
                iref = current_t'(560000);        // above the 550000 bound
            end else begin
                thermCur[4] = current_t'(221000); // above the 220000 bound
            end
            dataIn     = '1;
            dataInB    = '0;
            dataTherm  = '1;
            dataThermB = '0;
            dataIcal   = 5'd3;
            atbEna     = ATB_BIAS;
            waitPipeline();
            checkValue("held iout", iout, ioutSeen);
            checkValue("held ioutb", ioutb, ioutbSeen);
            checkValue("held ical", ical, icalSeen);
            checkValue("held atb1", atb1, atb1Seen);
            checkValue("held atb0", atb0, atb0Seen);
            checkDrives("held", drivesSeen);
            iref        = current_t'(NOM_IREF);
            thermCur[4] = current_t'(NOM_UNARY);
            waitPipeline();
            checkValue("resumed iout", iout, modelSum(1'b0));
            checkValue("resumed ioutb", ioutb, modelSum(1'b1));
            checkValue("resumed ical", ical, cellNominal(3));
            checkValue("resumed atb1", atb1, sum_t'(800));
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        seed       = 32'h94;
        setNominal();
        pdb = 1'b0;
        waitResetRelease(20);
        testReset();
        testSteering();
        testCalibration();
        testTestBus();
        testPowerDown();
        testHoldOnFault();
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
source/dacPkg.sv
source/biasMonitor.sv
source/steerDecode.sv
source/currentSummer.sv
source/outputStage.sv
source/currentSteeringDac.sv
dv/clockGen.sv
dv/tbCurrentSteeringDac.sv

// File: Bender.yml
package:
  name: current_steering_dac

sources:
  - source/dacPkg.sv
  - source/biasMonitor.sv
  - source/steerDecode.sv
  - source/currentSummer.sv
  - source/outputStage.sv
  - source/currentSteeringDac.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/tbCurrentSteeringDac.sv
